// ==== verilog/mips_macros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// machine word width, also the width of every address
`define MIPS_XLEN 32

// one-word lines in the data cache
// must be a power of two
`define MIPS_CACHE_LINES 16

// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

// register file depth, fixed by the 5-bit register fields
`define MIPS_NUM_REGS 32

// jal writes its return address here
`define MIPS_LINK_REG 5'd31

`endif

// ==== verilog/mips_pkg.sv ====
`include "mips_macros.svh"

package mips_pkg;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_jal   = 6'h03,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addi  = 6'h08,
        op_slti  = 6'h0a,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_lui   = 6'h0f,
        op_lw    = 6'h23,
        op_sw    = 6'h2b,
        op_halt  = 6'h3f
    } opcode_e;

    // r-type function field, inst[5:0]
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_jr   = 6'h08,
        fn_add  = 6'h20,
        fn_sub  = 6'h22,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    // operations the alu knows
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_lui
    } alu_op_e;

    // decoded control, one bundle from the control unit to the datapath
    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src;
        logic    reg_dest;
        logic    mem_or_reg;
        logic    reg_write_enable;
        logic    branch;
        logic    branch_ne;
        logic    jump;
        logic    jump_register;
        logic    link;
        logic    shift_amount;
        logic    zero_extend;
        logic    mem_read;
        logic    mem_write;
        logic    pc_we;
    } ctrl_t;

    // lane 0 is the least significant byte
    typedef logic [3:0][7:0] byte_lanes_t;

    // datapath to cache request
    typedef struct packed {
        logic [`MIPS_XLEN-1:0] addr;
        byte_lanes_t           wdata;
        logic                  read;
        logic                  write;
    } cache_req_t;

endpackage

// ==== verilog/alu.sv ====
`include "mips_macros.svh"

module alu (
    input  mips_pkg::alu_op_e     op,
    input  logic [`MIPS_XLEN-1:0] a,
    input  logic [`MIPS_XLEN-1:0] b,
    input  logic [4:0]            shamt,
    output logic [`MIPS_XLEN-1:0] result,
    output logic                  zero,
    output logic                  negative
);

    always_comb begin
        case (op)
            mips_pkg::alu_add:  result = a + b;
            // also the compare for beq and bne
            mips_pkg::alu_sub:  result = a - b;
            mips_pkg::alu_and:  result = a & b;
            mips_pkg::alu_or:   result = a | b;
            mips_pkg::alu_slt: begin
                // signed compare, result is 0 or 1
                result = '0;
                result[0] = $signed(a) < $signed(b);
            end
            mips_pkg::alu_sltu: begin
                result = '0;
                result[0] = a < b;
            end
            // shifts act on b, which carries rt
            mips_pkg::alu_sll:  result = b << shamt;
            mips_pkg::alu_srl:  result = b >> shamt;
            // immediate into the upper half
            mips_pkg::alu_lui:  result = {b[15:0], 16'h0000};
            default:            result = '0;
        endcase
    end

    // flags
    assign zero = (result == '0);
    assign negative = result[`MIPS_XLEN-1];

endmodule

// ==== verilog/control_unit.sv ====
`include "mips_macros.svh"

module control_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`MIPS_XLEN-1:0] inst,
    input  logic                  stall,
    output mips_pkg::ctrl_t       ctrl,
    output logic                  halted
);

    mips_pkg::opcode_e opcode;
    mips_pkg::funct_e  funct;
    mips_pkg::ctrl_t   dec;

    assign opcode = mips_pkg::opcode_e'(inst[31:26]);
    assign funct  = mips_pkg::funct_e'(inst[5:0]);

    // raw decode, independent of stall and halt
    always_comb begin
        dec = '0;
        dec.alu_op = mips_pkg::alu_add;
        // unknown opcodes behave as nops
        dec.pc_we = 1'b1;
        case (opcode)
            mips_pkg::op_rtype: begin
                dec.reg_dest = 1'b1;
                dec.reg_write_enable = 1'b1;
                case (funct)
                    mips_pkg::fn_add:  dec.alu_op = mips_pkg::alu_add;
                    mips_pkg::fn_sub:  dec.alu_op = mips_pkg::alu_sub;
                    mips_pkg::fn_and:  dec.alu_op = mips_pkg::alu_and;
                    mips_pkg::fn_or:   dec.alu_op = mips_pkg::alu_or;
                    mips_pkg::fn_slt:  dec.alu_op = mips_pkg::alu_slt;
                    mips_pkg::fn_sltu: dec.alu_op = mips_pkg::alu_sltu;
                    mips_pkg::fn_sll: begin
                        dec.alu_op = mips_pkg::alu_sll;
                        dec.shift_amount = 1'b1;
                    end
                    mips_pkg::fn_srl: begin
                        dec.alu_op = mips_pkg::alu_srl;
                        dec.shift_amount = 1'b1;
                    end
                    mips_pkg::fn_jr: begin
                        dec.jump_register = 1'b1;
                        dec.reg_write_enable = 1'b0;
                    end
                    // unsupported funct, no write
                    default: dec.reg_write_enable = 1'b0;
                endcase
            end
            mips_pkg::op_addi: begin
                dec.alu_src = 1'b1;
                dec.reg_write_enable = 1'b1;
            end
            mips_pkg::op_andi: begin
                dec.alu_op = mips_pkg::alu_and;
                dec.alu_src = 1'b1;
                dec.zero_extend = 1'b1;
                dec.reg_write_enable = 1'b1;
            end
            mips_pkg::op_ori: begin
                dec.alu_op = mips_pkg::alu_or;
                dec.alu_src = 1'b1;
                dec.zero_extend = 1'b1;
                dec.reg_write_enable = 1'b1;
            end
            mips_pkg::op_slti: begin
                dec.alu_op = mips_pkg::alu_slt;
                dec.alu_src = 1'b1;
                dec.reg_write_enable = 1'b1;
            end
            mips_pkg::op_lui: begin
                dec.alu_op = mips_pkg::alu_lui;
                dec.alu_src = 1'b1;
                dec.reg_write_enable = 1'b1;
            end
            mips_pkg::op_lw: begin
                // address is rs + sign extended offset
                dec.alu_src = 1'b1;
                dec.mem_read = 1'b1;
                dec.mem_or_reg = 1'b1;
                dec.reg_write_enable = 1'b1;
            end
            mips_pkg::op_sw: begin
                dec.alu_src = 1'b1;
                dec.mem_write = 1'b1;
            end
            mips_pkg::op_beq: begin
                dec.alu_op = mips_pkg::alu_sub;
                dec.branch = 1'b1;
            end
            mips_pkg::op_bne: begin
                dec.alu_op = mips_pkg::alu_sub;
                dec.branch_ne = 1'b1;
            end
            mips_pkg::op_j:   dec.jump = 1'b1;
            mips_pkg::op_jal: begin
                dec.jump = 1'b1;
                dec.link = 1'b1;
                dec.reg_write_enable = 1'b1;
            end
            // pc parks on the halt word
            mips_pkg::op_halt: dec.pc_we = 1'b0;
            default: ;
        endcase
    end

    // halt is sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (opcode == mips_pkg::op_halt) begin
            halted <= 1'b1;
        end
    end

    // stall holds pc and blocks the register write
    // halted freezes everything, memory traffic included
    // no memory traffic while reset is held
    always_comb begin
        ctrl = dec;
        ctrl.pc_we = dec.pc_we & ~stall & ~halted;
        ctrl.reg_write_enable = dec.reg_write_enable & ~stall & ~halted;
        ctrl.mem_read = dec.mem_read & ~halted & ~reset;
        ctrl.mem_write = dec.mem_write & ~halted & ~reset;
    end

endmodule

// ==== verilog/data_path.sv ====
`include "mips_macros.svh"

module data_path (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`MIPS_XLEN-1:0] inst,
    input  mips_pkg::ctrl_t       ctrl,
    input  mips_pkg::byte_lanes_t cache_rdata,
    output logic [`MIPS_XLEN-1:0] inst_addr,
    output mips_pkg::cache_req_t  cache_req
);

    logic [`MIPS_XLEN-1:0] pc_q;
    logic [`MIPS_XLEN-1:0] pc_plus4;
    logic [`MIPS_XLEN-1:0] pc_next;
    logic [`MIPS_XLEN-1:0] regs_q [`MIPS_NUM_REGS];

    logic [4:0]            rs;
    logic [4:0]            rt;
    logic [4:0]            rd;
    logic [`MIPS_XLEN-1:0] rs_val;
    logic [`MIPS_XLEN-1:0] rt_val;
    logic [`MIPS_XLEN-1:0] imm_ext;
    logic [`MIPS_XLEN-1:0] branch_off;

    logic [`MIPS_XLEN-1:0] alu_b;
    logic [4:0]            alu_shamt;
    logic [`MIPS_XLEN-1:0] alu_result;
    logic                  alu_zero;
    logic                  taken;

    logic [4:0]            wb_dest;
    logic [`MIPS_XLEN-1:0] wb_data;

    // instruction fields
    assign rs = inst[25:21];
    assign rt = inst[20:16];
    assign rd = inst[15:11];

    // register 0 is hardwired to zero
    assign rs_val = (rs == 5'd0) ? '0 : regs_q[rs];
    assign rt_val = (rt == 5'd0) ? '0 : regs_q[rt];

    // andi and ori zero extend, everything else sign extends
    assign imm_ext = ctrl.zero_extend ? {{(`MIPS_XLEN-16){1'b0}}, inst[15:0]}
                                      : {{(`MIPS_XLEN-16){inst[15]}}, inst[15:0]};

    // operand b, immediate or rt
    assign alu_b = ctrl.alu_src ? imm_ext : rt_val;
    // sll and srl take the shamt field
    assign alu_shamt = ctrl.shift_amount ? inst[10:6] : rs_val[4:0];

    alu alu_i (
        .op       (ctrl.alu_op),
        .a        (rs_val),
        .b        (alu_b),
        .shamt    (alu_shamt),
        .result   (alu_result),
        .zero     (alu_zero),
        // sign flag is not needed by this instruction subset
        .negative ()
    );

    // next pc
    assign pc_plus4 = pc_q + `MIPS_XLEN'd4;
    assign branch_off = {imm_ext[`MIPS_XLEN-3:0], 2'b00};
    // beq on equal, bne on not equal
    assign taken = (ctrl.branch & alu_zero) | (ctrl.branch_ne & ~alu_zero);

    always_comb begin
        if (ctrl.jump_register) begin
            pc_next = rs_val;
        end else if (ctrl.jump) begin
            // region bits come from pc+4
            pc_next = {pc_plus4[`MIPS_XLEN-1:28], inst[25:0], 2'b00};
        end else if (taken) begin
            pc_next = pc_plus4 + branch_off;
        end else begin
            pc_next = pc_plus4;
        end
    end

    // pc_we already folds in stall and halt
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= `MIPS_RESET_PC;
        end else if (ctrl.pc_we) begin
            pc_q <= pc_next;
        end
    end

    assign inst_addr = pc_q;

    // write back target, r31 for jal
    assign wb_dest = ctrl.link ? `MIPS_LINK_REG : (ctrl.reg_dest ? rd : rt);

    always_comb begin
        if (ctrl.link) begin
            wb_data = pc_plus4;
        end else if (ctrl.mem_or_reg) begin
            wb_data = cache_rdata;
        end else begin
            wb_data = alu_result;
        end
    end

    // registers start at zero so the program sees a known state
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (ctrl.reg_write_enable && wb_dest != 5'd0) begin
            regs_q[wb_dest] <= wb_data;
        end
    end

    // loads and stores address with rs + offset
    assign cache_req.addr = alu_result;
    assign cache_req.wdata = mips_pkg::byte_lanes_t'(rt_val);
    assign cache_req.read = ctrl.mem_read;
    assign cache_req.write = ctrl.mem_write;

endmodule

// ==== verilog/memory_cache.sv ====
`include "mips_macros.svh"

module memory_cache (
    input  logic                  clk,
    input  logic                  reset,
    input  mips_pkg::cache_req_t  req,
    input  mips_pkg::byte_lanes_t mem_data_out,
    output mips_pkg::byte_lanes_t rdata,
    output logic                  stall,
    output logic [`MIPS_XLEN-1:0] mem_addr,
    output mips_pkg::byte_lanes_t mem_data_in,
    output logic                  mem_write_en
);

    localparam int INDEX_BITS = $clog2(`MIPS_CACHE_LINES);
    localparam int TAG_BITS = `MIPS_XLEN - 2 - INDEX_BITS;

    // lookup serves requests, refill is the cycle after a fill
    typedef enum logic {
        st_lookup,
        st_refill
    } state_e;

    state_e state_q;

    logic [`MIPS_CACHE_LINES-1:0] valid_q;
    logic [TAG_BITS-1:0]          tag_q  [`MIPS_CACHE_LINES];
    mips_pkg::byte_lanes_t        data_q [`MIPS_CACHE_LINES];

    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;
    logic                  hit;
    logic                  fill;

    // word address split, byte offset dropped
    assign index = req.addr[2 +: INDEX_BITS];
    assign tag = req.addr[`MIPS_XLEN-1 -: TAG_BITS];

    assign hit = valid_q[index] && (tag_q[index] == tag);

    // a read miss fills the line in the same cycle
    // only from lookup, so a load never stalls twice
    assign fill = (state_q == st_lookup) && req.read && !hit;
    assign stall = fill;

    // read port, valid on a hit
    assign rdata = data_q[index];

    // memory port, word aligned
    assign mem_addr = {req.addr[`MIPS_XLEN-1:2], 2'b00};
    assign mem_data_in = req.wdata;
    // write-through, every store goes out
    assign mem_write_en = req.write;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= st_lookup;
        end else if (fill) begin
            state_q <= st_refill;
        end else begin
            state_q <= st_lookup;
        end
    end

    // all lines invalid after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[index] <= 1'b1;
        end
    end

    // line contents
    always_ff @(posedge clk) begin
        if (fill) begin
            // capture the word from memory
            tag_q[index] <= tag;
            data_q[index] <= mem_data_out;
        end else if (req.write && hit) begin
            // store hit keeps the line coherent
            // store miss does not allocate
            data_q[index] <= req.wdata;
        end
    end

endmodule

// ==== verilog/mips_core.sv ====
`include "mips_macros.svh"

module mips_core (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`MIPS_XLEN-1:0] inst,
    input  mips_pkg::byte_lanes_t mem_data_out,
    output logic [`MIPS_XLEN-1:0] inst_addr,
    output logic [`MIPS_XLEN-1:0] mem_addr,
    output mips_pkg::byte_lanes_t mem_data_in,
    output logic                  mem_write_en,
    output logic                  halted
);

    mips_pkg::ctrl_t       ctrl;
    mips_pkg::cache_req_t  cache_req;
    mips_pkg::byte_lanes_t cache_rdata;
    logic                  stall;

    // pc, registers, alu and next pc
    data_path data_path_i (
        .clk         (clk),
        .reset       (reset),
        .inst        (inst),
        .ctrl        (ctrl),
        .cache_rdata (cache_rdata),
        .inst_addr   (inst_addr),
        .cache_req   (cache_req)
    );

    // decode plus halt and stall gating
    control_unit control_unit_i (
        .clk    (clk),
        .reset  (reset),
        .inst   (inst),
        .stall  (stall),
        .ctrl   (ctrl),
        .halted (halted)
    );

    // data side, write-through to the memory port
    memory_cache memory_cache_i (
        .clk          (clk),
        .reset        (reset),
        .req          (cache_req),
        .mem_data_out (mem_data_out),
        .rdata        (cache_rdata),
        .stall        (stall),
        .mem_addr     (mem_addr),
        .mem_data_in  (mem_data_in),
        .mem_write_en (mem_write_en)
    );

endmodule

// ==== verif/mips_ref_model.svh ====
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

// 32-bit xorshift, one step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// initial data memory word, mixes every address bit
function automatic logic [31:0] fill_word(input int idx);
    logic [31:0] a;
    a = idx * 4;
    return (a * 32'h9e37_79b9) ^ 32'hc3a5_0f1e ^ {a[15:0], a[31:16]};
endfunction

// instruction-set model, runs the program held in imem
task automatic run_ref_model();
    logic [31:0] regs [32];
    logic [31:0] mem [DMEM_WORDS];
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_s;
    logic [31:0] imm_z;
    logic [31:0] ea;
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  sh;
    int          steps;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
        mem[i] = fill_word(i);
    end
    pc = `MIPS_RESET_PC;
    exp_count = 0;
    steps = 0;
    while (steps < 1000) begin
        w = imem[pc[9:2]];
        op = w[31:26];
        if (op == mips_pkg::op_halt) begin
            break;
        end
        rs = w[25:21];
        rt = w[20:16];
        rd = w[15:11];
        sh = w[10:6];
        fn = w[5:0];
        a = regs[rs];
        b = regs[rt];
        imm_s = {{16{w[15]}}, w[15:0]};
        imm_z = {16'h0000, w[15:0]};
        ea = a + imm_s;
        npc = pc + 32'd4;
        case (op)
            mips_pkg::op_rtype: begin
                case (fn)
                    mips_pkg::fn_add:  regs[rd] = a + b;
                    mips_pkg::fn_sub:  regs[rd] = a - b;
                    mips_pkg::fn_and:  regs[rd] = a & b;
                    mips_pkg::fn_or:   regs[rd] = a | b;
                    mips_pkg::fn_slt:  regs[rd] = {31'b0, $signed(a) < $signed(b)};
                    mips_pkg::fn_sltu: regs[rd] = {31'b0, a < b};
                    mips_pkg::fn_sll:  regs[rd] = b << sh;
                    mips_pkg::fn_srl:  regs[rd] = b >> sh;
                    mips_pkg::fn_jr:   npc = a;
                    default: ;
                endcase
            end
            mips_pkg::op_addi: regs[rt] = a + imm_s;
            mips_pkg::op_andi: regs[rt] = a & imm_z;
            mips_pkg::op_ori:  regs[rt] = a | imm_z;
            mips_pkg::op_slti: regs[rt] = {31'b0, $signed(a) < $signed(imm_s)};
            mips_pkg::op_lui:  regs[rt] = {w[15:0], 16'h0000};
            mips_pkg::op_lw:   regs[rt] = mem[ea[9:2]];
            mips_pkg::op_sw: begin
                mem[ea[9:2]] = b;
                exp_store_addr.push_back({ea[31:2], 2'b00});
                exp_store_data.push_back(b);
            end
            // branch offset counts words from pc+4
            mips_pkg::op_beq: if (a == b) npc = pc + 32'd4 + {imm_s[29:0], 2'b00};
            mips_pkg::op_bne: if (a != b) npc = pc + 32'd4 + {imm_s[29:0], 2'b00};
            mips_pkg::op_j:   npc = {npc[31:28], w[25:0], 2'b00};
            mips_pkg::op_jal: begin
                regs[31] = pc + 32'd4;
                npc = {npc[31:28], w[25:0], 2'b00};
            end
            default: ;
        endcase
        regs[0] = '0;
        pc = npc;
        exp_pc_trace.push_back(pc);
        exp_count++;
        steps++;
    end
    exp_final_pc = pc;
endtask

`endif

// ==== verif/mips_core_tb.sv ====
`include "mips_macros.svh"

module mips_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BODY_LEN = 200;
    localparam int PROG_LEN = 232;
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    localparam int TIMEOUT_CYCLES = 2 * PROG_LEN * 2 + 100;
    localparam int NTESTS = 5;
    localparam int T_RESET = 0;
    localparam int T_STORE = 1;
    localparam int T_PC = 2;
    localparam int T_COUNT = 3;
    localparam int T_HALT = 4;

    logic                  clk = 1'b0;
    logic                  reset;
    logic [31:0]           inst;
    mips_pkg::byte_lanes_t mem_data_out;
    logic [31:0]           inst_addr;
    logic [31:0]           mem_addr;
    mips_pkg::byte_lanes_t mem_data_in;
    logic                  mem_write_en;
    logic                  halted;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    int          slot_tag [IMEM_WORDS];
    int          slot_tgt [IMEM_WORDS];
    logic [31:0] rng;

    // expected results from the model
    logic [31:0] exp_store_addr [$];
    logic [31:0] exp_store_data [$];
    logic [31:0] exp_pc_trace [$];
    logic [31:0] exp_final_pc;
    int          exp_count;

    int          errs [NTESTS];
    string       test_names [NTESTS];
    int          store_idx = 0;
    int          pc_idx = 0;
    logic [31:0] last_pc = `MIPS_RESET_PC;
    logic        running = 1'b0;
    int          cycles = 0;

    `include "mips_ref_model.svh"

    mips_core mips_core_i (
        .clk          (clk),
        .reset        (reset),
        .inst         (inst),
        .mem_data_out (mem_data_out),
        .inst_addr    (inst_addr),
        .mem_addr     (mem_addr),
        .mem_data_in  (mem_data_in),
        .mem_write_en (mem_write_en),
        .halted       (halted)
    );

    always #4 clk = ~clk;

    // combinational memories
    assign inst = imem[inst_addr[9:2]];
    assign mem_data_out = dmem[mem_addr[9:2]];

    always @(posedge clk) begin
        if (mem_write_en) begin
            dmem[mem_addr[9:2]] <= mem_data_in;
        end
    end

    function automatic int rand_below(input int n);
        rng = xorshift32(rng);
        return int'(rng % n);
    endfunction

    // random body with forward control flow, then register dump and halt
    task automatic build_program();
        int          i;
        int          kind;
        int          off;
        int          tgt;
        logic [4:0]  rs;
        logic [4:0]  rs2;
        logic [4:0]  rdst;
        logic [5:0]  fn;
        logic [5:0]  op;
        for (int k = 0; k < IMEM_WORDS; k++) begin
            imem[k] = '0;
            slot_tag[k] = 0;
            slot_tgt[k] = 0;
        end
        // a store in the first slot shows any write leaking out during reset
        imem[0] = {mips_pkg::op_sw, 5'd0, 5'd0, 16'h0000};
        i = 1;
        while (i < BODY_LEN) begin
            kind = rand_below(16);
            rs = 5'(rand_below(32));
            rs2 = 5'(rand_below(32));
            // r30 and r31 stay out of random destinations
            rdst = 5'(1 + rand_below(29));
            // jr pair needs two slots and a target inside the body
            if (kind == 15 && i > BODY_LEN - 3) begin
                kind = 0;
            end
            case (kind)
                0, 1, 2, 3, 4, 5: begin
                    case (rand_below(8))
                        0: fn = mips_pkg::fn_add;
                        1: fn = mips_pkg::fn_sub;
                        2: fn = mips_pkg::fn_and;
                        3: fn = mips_pkg::fn_or;
                        4: fn = mips_pkg::fn_slt;
                        5: fn = mips_pkg::fn_sltu;
                        6: fn = mips_pkg::fn_sll;
                        default: fn = mips_pkg::fn_srl;
                    endcase
                    off = rand_below(32);
                    imem[i] = {6'h00, rs, rs2, rdst, off[4:0], fn};
                end
                6, 7, 8, 9: begin
                    case (rand_below(5))
                        0: op = mips_pkg::op_addi;
                        1: op = mips_pkg::op_andi;
                        2: op = mips_pkg::op_ori;
                        3: op = mips_pkg::op_slti;
                        default: op = mips_pkg::op_lui;
                    endcase
                    off = rand_below(65536);
                    imem[i] = {op, rs, rdst, off[15:0]};
                end
                10, 11: begin
                    off = 4 * rand_below(DMEM_WORDS);
                    imem[i] = {mips_pkg::op_lw, 5'd0, rdst, off[15:0]};
                end
                12: begin
                    off = 4 * rand_below(DMEM_WORDS);
                    imem[i] = {mips_pkg::op_sw, 5'd0, rs, off[15:0]};
                end
                13: begin
                    op = (rand_below(2) == 0) ? mips_pkg::op_beq : mips_pkg::op_bne;
                    imem[i] = {op, rs, rs2, 16'h0000};
                    slot_tag[i] = 1;
                    tgt = i + 1 + rand_below(8);
                    slot_tgt[i] = (tgt < BODY_LEN) ? tgt : BODY_LEN;
                end
                14: begin
                    op = (rand_below(2) == 0) ? mips_pkg::op_j : mips_pkg::op_jal;
                    imem[i] = {op, 26'h0};
                    slot_tag[i] = 2;
                    tgt = i + 1 + rand_below(8);
                    slot_tgt[i] = (tgt < BODY_LEN) ? tgt : BODY_LEN;
                end
                default: begin
                    // ori r30 with the target, then jr r30
                    imem[i] = {mips_pkg::op_ori, 5'd0, 5'd30, 16'h0000};
                    slot_tag[i] = 3;
                    tgt = i + 2 + rand_below(8);
                    slot_tgt[i] = (tgt < BODY_LEN) ? tgt : BODY_LEN;
                    i++;
                    imem[i] = {6'h00, 5'd30, 5'd0, 5'd0, 5'd0, mips_pkg::fn_jr};
                    slot_tag[i] = 4;
                end
            endcase
            i++;
        end
        // never land on a bare jr, r30 may hold an older target
        for (int k = 0; k < BODY_LEN; k++) begin
            if (slot_tag[k] >= 1 && slot_tag[k] <= 3) begin
                if (slot_tag[slot_tgt[k]] == 4) begin
                    slot_tgt[k]++;
                end
                case (slot_tag[k])
                    1: begin
                        off = slot_tgt[k] - (k + 1);
                        imem[k][15:0] = off[15:0];
                    end
                    2: begin
                        off = slot_tgt[k];
                        imem[k][25:0] = off[25:0];
                    end
                    default: begin
                        off = slot_tgt[k] * 4;
                        imem[k][15:0] = off[15:0];
                    end
                endcase
            end
        end
        // dump r1..r31 so every result reaches the memory port
        for (int r = 1; r < 32; r++) begin
            off = 4 * r;
            imem[BODY_LEN + r - 1] = {mips_pkg::op_sw, 5'd0, 5'(r), off[15:0]};
        end
        imem[PROG_LEN - 1] = {mips_pkg::op_halt, 26'h0};
    endtask

    task automatic report_test(input int t);
        if (errs[t] == 0) begin
            $display("test %-12s ok", test_names[t]);
        end else begin
            $display("test %-12s failed, %0d errors", test_names[t], errs[t]);
        end
    endtask

    // cycle limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the core did not halt within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // store stream and pc trace, sampled mid-cycle
    always @(negedge clk) begin
        if (running && !halted) begin
            if (mem_write_en) begin
                if (store_idx < exp_store_addr.size()) begin
                    assert (mem_addr == exp_store_addr[store_idx]) else begin
                        $display("ERROR mem_addr store %0d got %h expected %h",
                                 store_idx, mem_addr, exp_store_addr[store_idx]);
                        errs[T_STORE]++;
                    end
                    assert (mem_data_in == exp_store_data[store_idx]) else begin
                        $display("ERROR mem_data_in store %0d got %h expected %h",
                                 store_idx, mem_data_in, exp_store_data[store_idx]);
                        errs[T_STORE]++;
                    end
                end else begin
                    $display("store at %h is beyond the expected store stream", mem_addr);
                    errs[T_STORE]++;
                end
                store_idx++;
            end
            if (inst_addr != last_pc) begin
                if (pc_idx < exp_pc_trace.size()) begin
                    assert (inst_addr == exp_pc_trace[pc_idx]) else begin
                        $display("ERROR inst_addr step %0d got %h expected %h",
                                 pc_idx, inst_addr, exp_pc_trace[pc_idx]);
                        errs[T_PC]++;
                    end
                end else begin
                    $display("pc advanced more often than the model predicts");
                    errs[T_PC]++;
                end
                pc_idx++;
                last_pc = inst_addr;
            end
        end
    end

    initial begin
        int total;
        int failed;
        reset = 1'b1;
        rng = 32'd44881;
        test_names[T_RESET] = "reset";
        test_names[T_STORE] = "store_stream";
        test_names[T_PC] = "pc_trace";
        test_names[T_COUNT] = "inst_count";
        test_names[T_HALT] = "halt";
        for (int t = 0; t < NTESTS; t++) begin
            errs[t] = 0;
        end
        for (int k = 0; k < DMEM_WORDS; k++) begin
            dmem[k] = fill_word(k);
        end
        build_program();
        run_ref_model();

        // reset held two cycles
        repeat (2) begin
            @(posedge clk);
            #1;
            assert (inst_addr == `MIPS_RESET_PC) else begin
                $display("ERROR inst_addr in reset got %h expected %h",
                         inst_addr, `MIPS_RESET_PC);
                errs[T_RESET]++;
            end
            assert (halted == 1'b0 && mem_write_en == 1'b0) else begin
                $display("ERROR halted/mem_write_en in reset got %h/%h expected 0/0",
                         halted, mem_write_en);
                errs[T_RESET]++;
            end
        end
        reset = 1'b0;
        running = 1'b1;
        report_test(T_RESET);

        // timeout block ends the run if this never happens
        while (!halted) begin
            @(negedge clk);
        end
        @(negedge clk);

        assert (store_idx == exp_store_addr.size()) else begin
            $display("ERROR store count got %h expected %h",
                     store_idx, exp_store_addr.size());
            errs[T_STORE]++;
        end
        report_test(T_STORE);
        assert (inst_addr == exp_final_pc) else begin
            $display("ERROR inst_addr at halt got %h expected %h", inst_addr, exp_final_pc);
            errs[T_PC]++;
        end
        report_test(T_PC);
        assert (pc_idx == exp_count) else begin
            $display("ERROR pc advance count got %h expected %h", pc_idx, exp_count);
            errs[T_COUNT]++;
        end
        report_test(T_COUNT);

        // frozen after halt
        repeat (20) begin
            @(negedge clk);
            assert (inst_addr == exp_final_pc) else begin
                $display("ERROR inst_addr after halt got %h expected %h",
                         inst_addr, exp_final_pc);
                errs[T_HALT]++;
            end
            assert (mem_write_en == 1'b0 && halted == 1'b1) else begin
                $display("ERROR mem_write_en/halted after halt got %h/%h expected 0/1",
                         mem_write_en, halted);
                errs[T_HALT]++;
            end
        end
        report_test(T_HALT);

        total = 0;
        failed = 0;
        for (int t = 0; t < NTESTS; t++) begin
            total += errs[t];
            if (errs[t] != 0) begin
                failed++;
            end
        end
        $display("summary: %0d tests, %0d failed, %0d errors, %0d stores, %0d instructions",
                 NTESTS, failed, total, store_idx, pc_idx);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+verilog
+incdir+verif
verilog/mips_pkg.sv
verilog/alu.sv
verilog/control_unit.sv
verilog/data_path.sv
verilog/memory_cache.sv
verilog/mips_core.sv
verif/mips_core_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f list.f \
    --top-module mips_core_tb -o mips_core_sim
./obj_dir/mips_core_sim > sim.log
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
grep -q "ALL CHECKS PASSED" sim.log
